//--- bench/rv_core_trace.txt
// instr    mem_rdata pc       alu_res  wr_data  mem_wr   (all hex, one row per cycle after reset)
// Expected values are core outputs in that cycle, text after the sixth field is ignored
02000093 00000000 00000000 00000020 00000000 0  // addi x1, x0, 32
fe000113 00000000 00000004 ffffffe0 00000000 0  // addi x2, x0, -32
00108193 00000000 00000008 00000021 00000020 0  // addi x3, x1, 1
0c21e213 00000000 0000000c 000000e3 ffffffe0 0  // ori  x4, x3, 0xc2
0a327293 00000000 00000010 000000a3 00000021 0  // andi x5, x4, 0xa3
00112313 00000000 00000014 00000001 00000020 0  // slti x6, x2, 1     (-32 < 1)
fe10a393 00000000 00000018 00000000 00000020 0  // slti x7, x1, -31   (32 < -31 false)
00308433 00000000 0000001c 00000041 00000021 0  // add  x8, x1, x3
403084b3 00000000 00000020 ffffffff 00000021 0  // sub  x9, x1, x3
00527533 00000000 00000024 000000a3 000000a3 0  // and  x10, x4, x5
003165b3 00000000 00000028 ffffffe1 00000021 0  // or   x11, x2, x3
00112633 00000000 0000002c 00000001 00000020 0  // slt  x12, x2, x1   (signs differ)
0020a6b3 00000000 00000030 00000000 ffffffe0 0  // slt  x13, x1, x2
0030a423 00000000 00000034 00000028 00000021 1  // sw   x3, 8(x1)
0040a703 cafe1234 00000038 00000024 000000e3 0  // lw   x14, 4(x1)
00070793 0badf00d 0000003c cafe1234 00000000 0  // addi x15, x14, 0   (load data back)
00308863 00000000 00000040 ffffffff 00000021 0  // beq  x1, x3, +16   not taken
00108663 00000000 00000044 00000000 00000020 0  // beq  x1, x1, +12   taken
fe318ce3 00000000 00000050 00000000 00000021 0  // beq  x3, x3, -8    taken back
0280086f 00000000 00000048 00000041 00000041 0  // jal  x16, +40      links 0x4c
00080893 00000000 00000070 0000004c 00000000 0  // addi x17, x16, 0
00170933 0badf00d 00000074 cafe1254 00000020 0  // add  x18, x14, x1
00c12023 00000000 00000078 ffffffe0 00000001 1  // sw   x12, 0(x2)
00000013 00000000 0000007c 00000000 00000000 0  // nop

//--- bench/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_core;

  localparam int          RESET_CYCLES = 5;
  localparam int          SLACK_CYCLES = 10;               // Margin past trace end
  localparam logic [31:0] NOP_WORD     = 32'h0000_0013;    // ADDI x0, x0, 0
  localparam              TRACE_FILE   = "bench/rv_core_trace.txt";

  // One trace row, stimulus first, then expected outputs
  typedef struct packed {
    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] mem_rdata;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] write_data;
    logic                mem_write;
  } trace_entry_t;

  logic                CLK = 1'b0;
  logic                RST;
  rv_isa_pkg::instr_t  instr;
  logic [`RV_XLEN-1:0] mem_rdata;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] write_data;
  logic                mem_write;

  trace_entry_t trace_q[$];                                // Whole trace, in order
  int           cycle_count = 0;
  int           cycle_limit = RESET_CYCLES + SLACK_CYCLES; // Widened once trace is loaded
  string        load_error;

  //////////////////////////////////////////////////////////////////////
  // DUT, clock, timeout
  //////////////////////////////////////////////////////////////////////

  rv_core DUT (
    .CLK        (CLK),
    .RST        (RST),
    .instr      (instr),
    .mem_rdata  (mem_rdata),
    .pc         (pc),
    .alu_result (alu_result),
    .write_data (write_data),
    .mem_write  (mem_write)
  );

  always #50 CLK = ~CLK;  // 100 ns period

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      stop_with_failure($sformatf("Run did not finish within %0d cycles", cycle_limit));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  // Blank lines and // lines carry no data
  function automatic bit is_skip_line(input string line);
    byte c;
    for (int k = 0; k < line.len(); k++) begin
      c = line.getc(k);
      if (c != " " && c != "\t") begin
        return (c == "/" || c == "\n" || c == "\r");
      end
    end
    return 1'b1;
  endfunction

  // Fills trace_q, err stays empty on success
  task automatic load_trace(output string err);
    int          fd;
    int          line_no;
    int          fields;
    string       line;
    logic [31:0] f_instr, f_rdata, f_pc, f_alu, f_wdata, f_mw;
    err     = "";
    line_no = 0;
    fd      = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      err = $sformatf("Cannot open trace file %s", TRACE_FILE);
    end else begin
      while (err == "" && $fgets(line, fd) != 0) begin
        line_no++;
        if (!is_skip_line(line)) begin
          fields = $sscanf(line, "%h %h %h %h %h %h",
                           f_instr, f_rdata, f_pc, f_alu, f_wdata, f_mw);
          if (fields != 6 || f_mw > 1) begin  // mem_write column is a single bit
            err = $sformatf("Trace line %0d is malformed, six hex fields expected", line_no);
          end else begin
            trace_q.push_back(trace_entry_t'{f_instr, f_rdata, f_pc, f_alu, f_wdata, f_mw[0]});
          end
        end
      end
      $fclose(fd);
      if (err == "" && trace_q.size() == 0) begin
        err = "Trace file holds no entries";
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("[ERROR] time %0t %s expected %h actual %h", $time, name, expected, actual);
      stop_with_failure($sformatf("Output %s does not match the trace", name));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Trace replay
  //////////////////////////////////////////////////////////////////////

  // Drive on the rising edge, check on the falling edge
  task automatic run_trace();
    trace_entry_t entry;
    for (int i = 0; i < trace_q.size(); i++) begin
      entry = trace_q[i];
      if (i > 0) begin
        @(posedge CLK);  // First row goes out on the reset release edge
      end
      instr     <= rv_isa_pkg::instr_t'(entry.instr);
      mem_rdata <= entry.mem_rdata;
      @(negedge CLK);
      check_value("pc", pc, entry.pc);
      check_value("alu_result", alu_result, entry.alu_result);
      check_value("write_data", write_data, entry.write_data);
      check_value("mem_write", {{(`RV_XLEN-1){1'b0}}, mem_write},
                  {{(`RV_XLEN-1){1'b0}}, entry.mem_write});
    end
  endtask

  initial begin
    RST       = 1'b1;
    instr     = rv_isa_pkg::instr_t'(NOP_WORD);  // Harmless during reset
    mem_rdata = '0;
    load_trace(load_error);
    if (load_error != "") begin
      stop_with_failure(load_error);
    end else begin
      cycle_limit = trace_q.size() + RESET_CYCLES + SLACK_CYCLES;
      $display("Loaded %0d trace entries", trace_q.size());
      repeat (RESET_CYCLES) @(posedge CLK);
      RST <= 1'b0;
      run_trace();
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

//--- filelist.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/rv_regfile.sv
hdl/rv_imm_extend.sv
hdl/rv_alu.sv
hdl/rv_control.sv
hdl/rv_datapath.sv
hdl/rv_core.sv
bench/tb_rv_core.sv

//--- hdl/rv_alu.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_alu (
  input  logic [`RV_XLEN-1:0] a,       // rs1
  input  logic [`RV_XLEN-1:0] b,       // rs2 or immediate
  input  rv_ctrl_pkg::alu_op_t op,
  output logic [`RV_XLEN-1:0] result,
  output logic                zero     // Result is all zeros
);

  logic                inv_b;   // Subtract mode
  logic [`RV_XLEN-1:0] b_add;   // Adder B operand
  logic [`RV_XLEN-1:0] sum;
  logic                ovf;     // Signed overflow of a + b_add
  logic                lt;      // a < b, signed

  //////////////////////////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////////////////////////

  // SUB and SLT compute a + ~b + 1
  assign inv_b = (op == rv_ctrl_pkg::ALU_SUB) || (op == rv_ctrl_pkg::ALU_SLT);
  assign b_add = inv_b ? ~b : b;
  assign sum   = a + b_add + {{(`RV_XLEN-1){1'b0}}, inv_b};

  // Same operand signs, different result sign
  assign ovf = (a[`RV_XLEN-1] ~^ b_add[`RV_XLEN-1]) & (a[`RV_XLEN-1] ^ sum[`RV_XLEN-1]);
  assign lt  = sum[`RV_XLEN-1] ^ ovf;  // True sign of a - b

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op)
      rv_ctrl_pkg::ALU_ADD: result = sum;
      rv_ctrl_pkg::ALU_SUB: result = sum;
      rv_ctrl_pkg::ALU_AND: result = a & b;
      rv_ctrl_pkg::ALU_OR:  result = a | b;
      rv_ctrl_pkg::ALU_SLT: result = {{(`RV_XLEN-1){1'b0}}, lt};
      default:              result = 'x;
    endcase
  end

  // BEQ taken when rs1 - rs2 is zero
  assign zero = (result == '0);

endmodule

//--- hdl/rv_control.sv
`timescale 1ns/1ps

module rv_control (
  input  rv_isa_pkg::instr_t  instr,     // Current instruction
  input  logic                alu_zero,  // ALU result is zero
  output rv_ctrl_pkg::ctrl_t  ctrl       // Control word to datapath
);

  logic                     reg_write;
  rv_ctrl_pkg::imm_sel_t    imm_sel;
  logic                     alu_src_imm;
  logic                     mem_write;
  rv_ctrl_pkg::result_sel_t result_sel;
  logic                     branch;      // BEQ in flight
  logic                     jump;        // JAL in flight
  rv_ctrl_pkg::alu_class_t  alu_class;
  logic                     sub_r;       // R-type with funct7[5]
  rv_ctrl_pkg::alu_op_t     alu_op;

  //////////////////////////////////////////////////////////////////////
  // Main decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Idle values, overridden per opcode
    reg_write   = 1'b0;
    imm_sel     = rv_ctrl_pkg::IMM_I;
    alu_src_imm = 1'b0;
    mem_write   = 1'b0;
    result_sel  = rv_ctrl_pkg::RES_ALU;
    branch      = 1'b0;
    jump        = 1'b0;
    alu_class   = rv_ctrl_pkg::CLS_ADD;
    case (instr.r.opcode)
      rv_isa_pkg::OP_LOAD: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;                  // rs1 + imm address
        result_sel  = rv_ctrl_pkg::RES_MEM;
      end
      rv_isa_pkg::OP_STORE: begin
        imm_sel     = rv_ctrl_pkg::IMM_S;
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      rv_isa_pkg::OP_REG: begin
        reg_write   = 1'b1;
        alu_class   = rv_ctrl_pkg::CLS_FUNCT;
      end
      rv_isa_pkg::OP_IMM: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_class   = rv_ctrl_pkg::CLS_FUNCT;
      end
      rv_isa_pkg::OP_BRANCH: begin
        imm_sel     = rv_ctrl_pkg::IMM_B;
        branch      = 1'b1;
        alu_class   = rv_ctrl_pkg::CLS_SUB;  // rs1 - rs2 drives zero flag
      end
      rv_isa_pkg::OP_JAL: begin
        reg_write   = 1'b1;
        imm_sel     = rv_ctrl_pkg::IMM_J;
        result_sel  = rv_ctrl_pkg::RES_PC4;  // Link register gets PC+4
        jump        = 1'b1;
      end
      default: ;                             // Unsupported, outputs don't care
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // ALU decoder
  //////////////////////////////////////////////////////////////////////

  // ADDI has no SUB form, so funct7 only counts for R-type
  assign sub_r = instr.r.funct7[5] & (instr.r.opcode == rv_isa_pkg::OP_REG);

  always_comb begin
    case (alu_class)
      rv_ctrl_pkg::CLS_ADD: alu_op = rv_ctrl_pkg::ALU_ADD;
      rv_ctrl_pkg::CLS_SUB: alu_op = rv_ctrl_pkg::ALU_SUB;
      default: begin
        case (instr.r.funct3)
          rv_isa_pkg::F3_ADDSUB: alu_op = sub_r ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
          rv_isa_pkg::F3_SLT:    alu_op = rv_ctrl_pkg::ALU_SLT;
          rv_isa_pkg::F3_OR:     alu_op = rv_ctrl_pkg::ALU_OR;
          rv_isa_pkg::F3_AND:    alu_op = rv_ctrl_pkg::ALU_AND;
          default:               alu_op = rv_ctrl_pkg::alu_op_t'('x);
        endcase
      end
    endcase
  end

  // Control word with PC source, taken BEQ or any JAL
  assign ctrl = '{
    reg_write:     reg_write,
    imm_sel:       imm_sel,
    alu_src_imm:   alu_src_imm,
    mem_write:     mem_write,
    result_sel:    result_sel,
    pc_src_target: (branch & alu_zero) | jump,
    alu_op:        alu_op
  };

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core (
  input  logic                CLK,
  input  logic                RST,
  input  rv_isa_pkg::instr_t  instr,       // Instruction memory read data
  input  logic [`RV_XLEN-1:0] mem_rdata,   // Data memory read data
  output logic [`RV_XLEN-1:0] pc,          // Instruction memory address
  output logic [`RV_XLEN-1:0] alu_result,  // Data memory address
  output logic [`RV_XLEN-1:0] write_data,  // Data memory write data
  output logic                mem_write    // Data memory write strobe
);

  rv_ctrl_pkg::ctrl_t ctrl;
  logic               alu_zero;  // Back to control for BEQ

  //////////////////////////////////////////////////////////////////////
  // Control and datapath
  //////////////////////////////////////////////////////////////////////

  rv_control u_control (
    .instr    (instr),
    .alu_zero (alu_zero),
    .ctrl     (ctrl)
  );

  rv_datapath u_datapath (
    .CLK        (CLK),
    .RST        (RST),
    .instr      (instr),
    .ctrl       (ctrl),
    .mem_rdata  (mem_rdata),
    .pc         (pc),
    .alu_result (alu_result),
    .write_data (write_data),
    .alu_zero   (alu_zero)
  );

  assign mem_write = ctrl.mem_write;  // Unregistered, follows instr

endmodule

//--- hdl/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  // ALU operation codes
  typedef enum logic [2:0] {
    ALU_ADD = 3'b000,
    ALU_SUB = 3'b001,
    ALU_AND = 3'b010,
    ALU_OR  = 3'b011,
    ALU_SLT = 3'b101   // Signed compare, result is 0 or 1
  } alu_op_t;

  // Immediate format select for the extend unit
  typedef enum logic [1:0] {
    IMM_I = 2'b00,
    IMM_S = 2'b01,
    IMM_B = 2'b10,
    IMM_J = 2'b11
  } imm_sel_t;

  // Register write-back source
  typedef enum logic [1:0] {
    RES_ALU = 2'b00,  // ALU result
    RES_MEM = 2'b01,  // Load data
    RES_PC4 = 2'b10   // Link address for JAL
  } result_sel_t;

  //////////////////////////////////////////////////////////////////////
  // Control word, control unit to datapath
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        reg_write;      // Regfile write enable
    imm_sel_t    imm_sel;        // Immediate format
    logic        alu_src_imm;    // ALU B from immediate
    logic        mem_write;      // Data memory write strobe
    result_sel_t result_sel;     // Write-back mux select
    logic        pc_src_target;  // Next PC is PC + imm
    alu_op_t     alu_op;         // ALU operation
  } ctrl_t;

  // Internal ALU decode classes
  // CLS_ADD for address math
  // CLS_SUB for BEQ compare
  // CLS_FUNCT decodes funct3
  typedef enum logic [1:0] {
    CLS_ADD   = 2'b00,
    CLS_SUB   = 2'b01,
    CLS_FUNCT = 2'b10
  } alu_class_t;

endpackage

//--- hdl/rv_datapath.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_datapath (
  input  logic                CLK,
  input  logic                RST,
  input  rv_isa_pkg::instr_t  instr,       // From instruction memory
  input  rv_ctrl_pkg::ctrl_t  ctrl,        // From control unit
  input  logic [`RV_XLEN-1:0] mem_rdata,   // Load data
  output logic [`RV_XLEN-1:0] pc,          // Fetch address
  output logic [`RV_XLEN-1:0] alu_result,  // Also data address
  output logic [`RV_XLEN-1:0] write_data,  // Store data, rs2
  output logic                alu_zero
);

  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_target;  // Branch or jump destination
  logic [`RV_XLEN-1:0] pc_next;
  logic [`RV_XLEN-1:0] imm_ext;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] result;     // Write-back value

  //////////////////////////////////////////////////////////////////////
  // Program counter
  //////////////////////////////////////////////////////////////////////

  assign pc_plus4  = pc + `RV_XLEN'd4;
  assign pc_target = pc + imm_ext;                              // B or J offset
  assign pc_next   = ctrl.pc_src_target ? pc_target : pc_plus4;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register file, immediate, ALU
  //////////////////////////////////////////////////////////////////////

  rv_regfile u_regfile (
    .CLK      (CLK),
    .rs1_addr (instr.r.rs1),
    .rs2_addr (instr.r.rs2),
    .rd_addr  (instr.r.rd),
    .rd_we    (ctrl.reg_write),
    .rd_data  (result),
    .rs1_data (rs1_data),
    .rs2_data (write_data)   // rs2 goes straight out for SW
  );

  rv_imm_extend u_imm_extend (
    .instr   (instr),
    .imm_sel (ctrl.imm_sel),
    .imm     (imm_ext)
  );

  assign alu_b = ctrl.alu_src_imm ? imm_ext : write_data;

  rv_alu u_alu (
    .a      (rs1_data),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // Write-back mux
  always_comb begin
    case (ctrl.result_sel)
      rv_ctrl_pkg::RES_ALU: result = alu_result;
      rv_ctrl_pkg::RES_MEM: result = mem_rdata;
      rv_ctrl_pkg::RES_PC4: result = pc_plus4;    // JAL link
      default:              result = 'x;
    endcase
  end

endmodule

//--- hdl/rv_imm_extend.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_imm_extend (
  input  rv_isa_pkg::instr_t    instr,    // Fetched word
  input  rv_ctrl_pkg::imm_sel_t imm_sel,  // Format to decode
  output logic [`RV_XLEN-1:0]   imm       // Sign-extended immediate
);

  // Each format reads its own union view, sign from instr[31]
  always_comb begin
    case (imm_sel)
      rv_ctrl_pkg::IMM_I: begin
        imm = {{(`RV_XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
      end
      rv_ctrl_pkg::IMM_S: begin
        imm = {{(`RV_XLEN-12){instr.s.imm_11_5[6]}},
               instr.s.imm_11_5, instr.s.imm_4_0};
      end
      rv_ctrl_pkg::IMM_B: begin  // Halfword offset, bit 0 always zero
        imm = {{(`RV_XLEN-13){instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
               instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      rv_ctrl_pkg::IMM_J: begin  // 21-bit jump offset
        imm = {{(`RV_XLEN-21){instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
               instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      default: imm = 'x;
    endcase
  end

endmodule

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,  // LW
    OP_STORE  = 7'b0100011,  // SW
    OP_REG    = 7'b0110011,  // R-type ALU
    OP_IMM    = 7'b0010011,  // I-type ALU
    OP_BRANCH = 7'b1100011,  // BEQ
    OP_JAL    = 7'b1101111   // JAL
  } opcode_t;

  // ALU funct3, shared by R-type and I-type
  typedef enum logic [2:0] {
    F3_ADDSUB = 3'b000,
    F3_SLT    = 3'b010,
    F3_OR     = 3'b110,
    F3_AND    = 3'b111
  } funct3_alu_t;

  //////////////////////////////////////////////////////////////////////
  // Instruction formats, MSB first
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;    // Bit 5 picks SUB
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;   // Sits where rd would be
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;    // Sign bit
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm_20;    // Sign bit
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } j_fmt_t;

  // One fetched word, five views
  typedef union packed {
    r_fmt_t r;  // Also the common view of opcode, rs1, rs2, rd
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    j_fmt_t j;
  } instr_t;

endpackage

//--- hdl/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Core widths, all fixed by RV32I
//////////////////////////////////////////////////////////////////////

// Data and address word
`define RV_XLEN 32

// Integer register file
`define RV_REG_COUNT  32  // x0 to x31
`define RV_REG_ADDR_W 5   // rs1, rs2, rd field width

//////////////////////////////////////////////////////////////////////
// Reset state
//////////////////////////////////////////////////////////////////////

// First fetch address after RST
`define RV_RESET_PC 32'h0000_0000

`endif

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile (
  input  logic                      CLK,
  input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,  // Read port A address
  input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,  // Read port B address
  input  logic [`RV_REG_ADDR_W-1:0] rd_addr,   // Write address
  input  logic                      rd_we,     // Write enable
  input  logic [`RV_XLEN-1:0]       rd_data,   // Write data
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data
);

  // Storage, entry 0 exists but never reads back
  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // Combinational, x0 hardwired to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // Same edge as the PC update
  always_ff @(posedge CLK) begin
    if (rd_we) begin
      regs[rd_addr] <= rd_data;  // Writes to x0 are masked on read
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_rv_core -Mdir obj_dir -o sim_tb_rv_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb_rv_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
